// ==== conv_pkg.sv ====
/*
  shared widths, lane count, word and array types, lane masks
  and the state encoding for the convolution stage
*/

package conv_pkg;

  // ====================================================================
  // sizes
  // ====================================================================

  // bits in one data word
  localparam int word_width = 32;

  // number of lanes, one multiplier each
  localparam int array_length = 8;

  // ====================================================================
  // data types
  // ====================================================================

  // one unsigned integer word, no fraction bits
  typedef logic [word_width-1:0] word_t;

  // whole array as one packed vector, element 0 in the low bits
  typedef word_t [array_length-1:0] word_array_t;

  // one flag per lane
  typedef logic [array_length-1:0] lane_mask_t;

  // ====================================================================
  // state encoding
  // ====================================================================

  // idle   waiting for operands
  // calc   lanes iterating
  // done   result held until the consumer takes it
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } conv_state_t;

endpackage

// ==== fixed_point_multiplier.sv ====
/*
  iterative unsigned shift-and-add multiplier, low word of the product,
  early exit once the remaining multiplier bits are zero
*/

`timescale 1ns/1ps

module fixed_point_multiplier (
  input  logic            clk,
  input  logic            reset,

  // operand channel
  input  logic            recv_val,
  output logic            recv_rdy,
  input  conv_pkg::word_t a,
  input  conv_pkg::word_t b,

  // product channel
  output logic            send_val,
  input  logic            send_rdy,
  output conv_pkg::word_t c
);

  // ====================================================================
  // control
  // ====================================================================

  conv_pkg::conv_state_t state_q;
  conv_pkg::conv_state_t state_d;

  // operand registers and running sum
  conv_pkg::word_t acc_q;
  conv_pkg::word_t a_q;
  conv_pkg::word_t b_q;

  // term added this cycle, zero when the current b bit is clear
  conv_pkg::word_t partial;

  logic accept;
  logic b_empty;

  assign accept  = recv_val && (state_q == conv_pkg::idle);
  assign b_empty = (b_q == '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      conv_pkg::idle: begin
        if (recv_val) begin
          state_d = conv_pkg::calc;
        end
      end
      conv_pkg::calc: begin
        // no set bits left, the sum is final
        if (b_empty) begin
          state_d = conv_pkg::done;
        end
      end
      conv_pkg::done: begin
        if (send_rdy) begin
          state_d = conv_pkg::idle;
        end
      end
      default: begin
        state_d = conv_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= conv_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  // ====================================================================
  // datapath
  // ====================================================================

  assign partial = b_q[0] ? a_q : '0;

  // one multiplier bit per cycle, a moves left as b moves right
  always_ff @(posedge clk) begin
    if (accept) begin
      acc_q <= '0;
      a_q   <= a;
      b_q   <= b;
    end else if ((state_q == conv_pkg::calc) && !b_empty) begin
      // upper product bits fall off, only the low word is kept
      acc_q <= acc_q + partial;
      a_q   <= a_q << 1;
      b_q   <= b_q >> 1;
    end
  end

  // outputs
  assign recv_rdy = (state_q == conv_pkg::idle);
  assign send_val = (state_q == conv_pkg::done);
  assign c        = acc_q;

  // ====================================================================
  // checks
  // ====================================================================

  // a waiting product must not move or drop before it is taken
  property hold_until_taken;
    @(posedge clk) disable iff (reset)
      (send_val && !send_rdy) |=> (send_val && $stable(c));
  endproperty

  assert property (hold_until_taken)
    else $error("multiplier product changed while send_rdy was low");

endmodule

// ==== convolution_block.sv ====
/*
  convolution block: launches eight lane multipliers on a joint
  input and filter transfer, gathers the products into one output array
*/

`timescale 1ns/1ps

module convolution_block (
  input  logic                  clk,
  input  logic                  reset,

  // input array channel
  input  logic                  in_val,
  output logic                  in_rdy,
  input  conv_pkg::word_array_t in_msg,

  // filter array channel
  input  logic                  filter_val,
  output logic                  filter_rdy,
  input  conv_pkg::word_array_t filter_msg,

  // output array channel
  output logic                  out_val,
  input  logic                  out_rdy,
  output conv_pkg::word_array_t out_msg
);

  // ====================================================================
  // block state machine
  // ====================================================================

  conv_pkg::conv_state_t state_q;
  conv_pkg::conv_state_t state_d;

  // per lane handshake flags
  conv_pkg::lane_mask_t lane_rdy;
  conv_pkg::lane_mask_t lane_val;

  // lane products, lane i in element i
  conv_pkg::word_array_t lane_prod;

  logic lane_start;
  logic lane_send_rdy;
  logic all_lanes_done;

  // both arrays must be present, they transfer on the same edge
  assign lane_start = in_val && filter_val && (state_q == conv_pkg::idle);

  // lanes release only when the output array is actually taken
  assign lane_send_rdy = out_val && out_rdy;

  assign all_lanes_done = &lane_val;

  always_comb begin
    state_d = state_q;
    case (state_q)
      conv_pkg::idle: begin
        if (in_val && filter_val) begin
          state_d = conv_pkg::calc;
        end
      end
      conv_pkg::calc: begin
        // slowest lane decides when the array is complete
        if (all_lanes_done) begin
          state_d = conv_pkg::done;
        end
      end
      conv_pkg::done: begin
        if (out_rdy) begin
          state_d = conv_pkg::idle;
        end
      end
      default: begin
        state_d = conv_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= conv_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  // input side follows the state, filter side follows the lanes
  always_comb begin
    in_rdy     = (state_q == conv_pkg::idle);
    filter_rdy = &lane_rdy;
    out_val    = (state_q == conv_pkg::done);
  end

  // ====================================================================
  // lane multipliers
  // ====================================================================

  // lane i takes input word i and filter word (n - 1 - i)
  for (genvar i = 0; i < conv_pkg::array_length; i++) begin : g_lane
    fixed_point_multiplier lane_mult (
      .clk      (clk),
      .reset    (reset),
      .recv_val (lane_start),
      .recv_rdy (lane_rdy[i]),
      .a        (in_msg[i]),
      .b        (filter_msg[conv_pkg::array_length - 1 - i]),
      .send_val (lane_val[i]),
      .send_rdy (lane_send_rdy),
      .c        (lane_prod[i])
    );
  end

  // products are held in the lanes until release
  assign out_msg = lane_prod;

  // ====================================================================
  // checks
  // ====================================================================

  // block and lanes agree on when a new array can start
  assert property (@(posedge clk) disable iff (reset) in_rdy == filter_rdy)
    else $error("in_rdy and filter_rdy disagree");

  // nothing is offered while the lanes sit idle
  assert property (@(posedge clk) disable iff (reset)
      (&lane_rdy) |-> !out_val)
    else $error("out_val high while idle");

endmodule

// ==== conv_top.sv ====
/*
  top level of the convolution stage, outside channels
  wired to the convolution block
*/

`timescale 1ns/1ps

module conv_top (
  input  logic                  clk,
  input  logic                  reset,

  // input array
  input  logic                  in_val,
  output logic                  in_rdy,
  input  conv_pkg::word_array_t in_msg,

  // filter array
  input  logic                  filter_val,
  output logic                  filter_rdy,
  input  conv_pkg::word_array_t filter_msg,

  // output array
  output logic                  out_val,
  input  logic                  out_rdy,
  output conv_pkg::word_array_t out_msg
);

  // ====================================================================
  // convolution core
  // ====================================================================

  // one array in flight at a time
  convolution_block conv_block (
    .clk        (clk),
    .reset      (reset),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .in_msg     (in_msg),
    .filter_val (filter_val),
    .filter_rdy (filter_rdy),
    .filter_msg (filter_msg),
    .out_val    (out_val),
    .out_rdy    (out_rdy),
    .out_msg    (out_msg)
  );

endmodule

// ==== conv_tb_vectors.svh ====
/*
  stimulus table for the convolution testbench, fixed and
  LCG filled rows with filter stall and back-pressure columns
*/

`ifndef CONV_TB_VECTORS_SVH
`define CONV_TB_VECTORS_SVH

localparam int row_count = 12;

// columns: input array, filter array,
// cycles the filter lags the input, cycles out_rdy stays low
typedef struct packed {
  conv_pkg::word_array_t in_arr;
  conv_pkg::word_array_t filt_arr;
  logic [3:0]            filter_delay;
  logic [3:0]            hold_cycles;
} vector_t;

vector_t vectors [row_count];

logic [31:0] lcg_state;

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// next random word, advances the generator
function automatic logic [31:0] random_word();
  lcg_state = lcg_next(lcg_state);
  return lcg_state;
endfunction

task automatic load_vectors();
  conv_pkg::word_array_t ia;
  conv_pkg::word_array_t fa;
  lcg_state = 32'h4aa0;
  for (int r = 0; r < row_count; r++) begin
    for (int k = 0; k < conv_pkg::array_length; k++) begin
      case (r)
        // ramp against ramp
        0: begin
          ia[k] = conv_pkg::word_t'(k + 1);
          fa[k] = conv_pkg::word_t'(k + 1);
        end
        // zero operands on both sides
        1: begin
          ia[k] = (k % 2 == 1) ? 32'h0 : 32'h1234_5678 + conv_pkg::word_t'(k);
          fa[k] = (k < 4) ? 32'h0 : 32'h0000_00ff;
        end
        // filter of one passes the input through
        2: begin
          ia[k] = 32'hdead_beef ^ conv_pkg::word_t'(k);
          fa[k] = 32'h1;
        end
        // input of one shows the filter order
        3: begin
          ia[k] = 32'h1;
          fa[k] = 32'h0f0f_0000 | conv_pkg::word_t'(k);
        end
        // all ones, longest latency, truncated product
        4: begin
          ia[k] = 32'hffff_ffff;
          fa[k] = 32'hffff_ffff;
        end
        // random, lane latencies spread by shifting the filter
        default: begin
          ia[k] = random_word();
          fa[k] = random_word() >> (4 * ((r + k) % 8));
        end
      endcase
    end
    vectors[r].in_arr = ia;
    vectors[r].filt_arr = fa;
    vectors[r].filter_delay = (r == 6) ? 4'd5 : (r == 10) ? 4'd2 : 4'd0;
    vectors[r].hold_cycles = (r == 4) ? 4'd4 : (r == 9) ? 4'd6 : (r == 10) ? 4'd3 : 4'd0;
  end
endtask

`endif

// ==== conv_tb.sv ====
/*
  testbench for the convolution stage, table driven stimulus,
  reference products, handshake checks and watchdog
*/

`timescale 1ns/1ps

module conv_tb;

  localparam int clk_period = 8;

  logic                  clk;
  logic                  reset;
  logic                  in_val;
  logic                  in_rdy;
  conv_pkg::word_array_t in_msg;
  logic                  filter_val;
  logic                  filter_rdy;
  conv_pkg::word_array_t filter_msg;
  logic                  out_val;
  logic                  out_rdy;
  conv_pkg::word_array_t out_msg;

  int mismatch_count;
  int protocol_count;
  int input_count;
  int output_count;

  `include "conv_tb_vectors.svh"

  // worst row is about 36 cycles, margin covers stalls and holds
  localparam int watchdog_cycles = row_count * 40 + 64;

  conv_top UUT (
    .clk        (clk),
    .reset      (reset),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .in_msg     (in_msg),
    .filter_val (filter_val),
    .filter_rdy (filter_rdy),
    .filter_msg (filter_msg),
    .out_val    (out_val),
    .out_rdy    (out_rdy),
    .out_msg    (out_msg)
  );

  // ====================================================================
  // clock and watchdog
  // ====================================================================

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  // ====================================================================
  // transfer counters
  // ====================================================================

  // joint input transfers and output transfers, seen at the edge itself
  always @(posedge clk) begin
    if (!reset) begin
      if (in_val && in_rdy && filter_val && filter_rdy) begin
        input_count++;
      end
      if (out_val && out_rdy) begin
        output_count++;
      end
    end
  end

  // ====================================================================
  // reference and checks
  // ====================================================================

  // lane i is input word i times filter word (n - 1 - i), low word kept
  function automatic conv_pkg::word_t expected_lane(
    input conv_pkg::word_array_t in_arr,
    input conv_pkg::word_array_t filt_arr,
    input int                    lane
  );
    logic [63:0] full;
    full = 64'(in_arr[lane]) * 64'(filt_arr[conv_pkg::array_length - 1 - lane]);
    return full[conv_pkg::word_width-1:0];
  endfunction

  task automatic protocol_error(input string msg);
    protocol_count++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_output(input vector_t row, input int row_index);
    conv_pkg::word_t want;
    for (int i = 0; i < conv_pkg::array_length; i++) begin
      want = expected_lane(row.in_arr, row.filt_arr, i);
      assert (out_msg[i] == want)
        else begin
          mismatch_count++;
          $display("MISMATCH at %0t: row %0d lane %0d got %08h expected %08h",
                   $time, row_index, i, out_msg[i], want);
        end
    end
  endtask

  // ====================================================================
  // one row from presentation to release
  // ====================================================================

  task automatic apply_row(input vector_t row, input int row_index);
    conv_pkg::word_array_t held;
    in_val     = 1'b1;
    in_msg     = row.in_arr;
    filter_msg = row.filt_arr;
    filter_val = (row.filter_delay == 0);
    out_rdy    = (row.hold_cycles == 0);
    // input alone must not start the block
    repeat (row.filter_delay) begin
      @(negedge clk);
      assert (in_rdy && filter_rdy && !out_val)
        else protocol_error("input accepted or output shown before the filter arrived");
    end
    filter_val = 1'b1;
    assert (in_rdy && filter_rdy)
      else protocol_error("block not ready for a new array");
    @(negedge clk);
    in_val     = 1'b0;
    filter_val = 1'b0;
    assert (!in_rdy)
      else protocol_error("in_rdy still high after the joint transfer");
    while (!out_val) begin
      @(negedge clk);
    end
    check_output(row, row_index);
    if (row.hold_cycles != 0) begin
      held = out_msg;
      repeat (row.hold_cycles) begin
        @(negedge clk);
        assert (out_val && !in_rdy && (out_msg == held))
          else protocol_error("output dropped or changed under back-pressure");
      end
      out_rdy = 1'b1;
    end
    @(negedge clk);
    assert (!out_val)
      else protocol_error("output still offered after it was taken");
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================

  initial begin
    reset          = 1'b1;
    in_val         = 1'b0;
    in_msg         = '0;
    filter_val     = 1'b0;
    filter_msg     = '0;
    out_rdy        = 1'b1;
    mismatch_count = 0;
    protocol_count = 0;
    input_count    = 0;
    output_count   = 0;
    load_vectors();

    repeat (2) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    assert (in_rdy && filter_rdy && !out_val)
      else protocol_error("wrong channel flags after reset");

    for (int r = 0; r < row_count; r++) begin
      apply_row(vectors[r], r);
    end

    assert (input_count == row_count)
      else protocol_error("number of accepted arrays differs from number of rows");
    assert (output_count == input_count)
      else protocol_error("number of outputs differs from number of accepted inputs");

    $display("errors: %0d mismatches, %0d protocol, %0d of %0d outputs",
             mismatch_count, protocol_count, output_count, row_count);
    if (mismatch_count == 0 && protocol_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+.
conv_pkg.sv
fixed_point_multiplier.sv
convolution_block.sv
conv_top.sv
conv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the convolution testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
  -f sim.f \
  --top-module conv_tb \
  -o conv_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/conv_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" "$log"; then
  exit 0
else
  echo "pass message not found in $log"
  exit 1
fi
